// File: Makefile
# Verilator build and run of the replay queue testbench

VERILATOR ?= verilator
TOP       ?= tb_addr_replay
FILELIST  ?= src.f
BUILD_DIR ?= obj_dir
LOG       ?= sim.log
VFLAGS    ?= --binary --timing -Wno-fatal -j 0

.PHONY: sim clean

# build, run, then look for the pass line in the log
sim:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -f $(FILELIST) \
		--Mdir $(BUILD_DIR) -o V$(TOP)
	./$(BUILD_DIR)/V$(TOP) | tee $(LOG)
	grep -q "^Test passed$$" $(LOG)

clean:
	rm -rf $(BUILD_DIR) $(LOG)

// File: sim/tb_addr_replay.sv
/*
  testbench for the conflict replay path
  applies a table of lane groups, tracks the expected replay
  order in a queue model and checks ordering, back-pressure,
  flush and skip behavior against it
*/

`timescale 1ns/1ps

module tb_addr_replay;
  import replay_pkg::*;

  localparam int CLK_PERIOD = 4;
  localparam int RESET_CYCLES = 16;
  localparam int DRAIN_LIMIT = 64;
  localparam int NUM_ROWS = 20;

  // one expected op in output port order
  typedef struct packed {
    vaddr_t  addr;
    reg_no_t rg;
    size_t   size;
    lsq_t    lsq;
    logic    thread;
  } exp_op_t;

  // base 0 selects random fields and a random conflict mask
  typedef struct {
    lane_mask_t mask;
    int         base;
    bit         exc;
    bit         ready;
    bit         respect;
    int         reps;
  } row_t;

  // mask, base, except, out_ready, respect skip, repeats
  row_t table_rows [NUM_ROWS] = '{
    '{3'b000, 32'h100, 1'b0, 1'b1, 1'b1, 2},
    '{3'b111, 32'h200, 1'b0, 1'b1, 1'b1, 1},
    '{3'b000, 32'h010, 1'b0, 1'b1, 1'b1, 4},
    '{3'b101, 32'h300, 1'b0, 1'b1, 1'b1, 1},
    '{3'b010, 32'h400, 1'b0, 1'b1, 1'b1, 1},
    '{3'b110, 32'h500, 1'b0, 1'b1, 1'b1, 1},
    '{3'b000, 32'h010, 1'b0, 1'b1, 1'b1, 6},
    '{3'b111, 32'h600, 1'b0, 1'b0, 1'b1, 6},
    '{3'b000, 32'h010, 1'b0, 1'b0, 1'b1, 4},
    '{3'b000, 32'h010, 1'b0, 1'b1, 1'b1, 20},
    '{3'b011, 32'h700, 1'b0, 1'b0, 1'b1, 3},
    '{3'b111, 32'h800, 1'b1, 1'b0, 1'b1, 1},
    '{3'b000, 32'h010, 1'b0, 1'b1, 1'b1, 4},
    '{3'b000, 32'h000, 1'b0, 1'b1, 1'b1, 20},
    '{3'b000, 32'h000, 1'b0, 1'b0, 1'b1, 6},
    '{3'b000, 32'h010, 1'b0, 1'b1, 1'b1, 24},
    '{3'b111, 32'h900, 1'b0, 1'b1, 1'b1, 2},
    '{3'b000, 32'h010, 1'b1, 1'b1, 1'b1, 1},
    '{3'b100, 32'hb00, 1'b0, 1'b0, 1'b0, 5},
    '{3'b000, 32'h010, 1'b0, 1'b1, 1'b1, 16}
  };

  logic       clk = 1'b0;
  logic       rst;
  logic       except;
  lane_mask_t in_conflict;
  vaddr_t     in_addr   [LANE_COUNT];
  reg_no_t    in_reg    [LANE_COUNT];
  size_t      in_size   [LANE_COUNT];
  lsq_t       in_lsq    [LANE_COUNT];
  logic       in_thread [LANE_COUNT];
  logic       out_ready;
  logic       out_valid;
  vaddr_t     out_addr;
  reg_no_t    out_reg;
  size_t      out_size;
  lsq_t       out_lsq;
  logic       out_thread;
  logic       skip;

  // expected ops in replay order and the lanes left in each entry
  exp_op_t exp_q [$];
  int      ent_left [$];
  // group sampled at the last edge and not yet in the queue
  exp_op_t fly_q [$];

  integer  seed = 42781;
  int      checks = 0;
  int      errors = 0;
  bit      held = 1'b0;
  exp_op_t held_op;
  bit      last_exc = 1'b0;
  int      last_occ = 0;

  always #(CLK_PERIOD / 2) clk = ~clk;

  addr_replay_top DUT (
    .clk, .rst, .except,
    .in_conflict, .in_addr, .in_reg, .in_size, .in_lsq, .in_thread,
    .out_ready, .out_valid, .out_addr, .out_reg, .out_size, .out_lsq, .out_thread,
    .skip
  );

  task automatic compare_field(input string name, input logic [63:0] got,
                               input logic [63:0] exp);
    checks++;
    assert (got === exp) else begin
      errors++;
      $display("Error: %s got 0x%0h expected 0x%0h at %0t", name, got, exp, $time);
    end
  endtask

  task automatic compare_outputs(input exp_op_t e);
    compare_field("out_addr", 64'(out_addr), 64'(e.addr));
    compare_field("out_reg", 64'(out_reg), 64'(e.rg));
    compare_field("out_size", 64'(out_size), 64'(e.size));
    compare_field("out_lsq", 64'(out_lsq), 64'(e.lsq));
    compare_field("out_thread", 64'(out_thread), 64'(e.thread));
  endtask

  // drives one group, checks mid-cycle and advances the model by one clock
  task automatic run_cycle(input row_t row, input int k);
    exp_op_t    op;
    exp_op_t    sample_q [$];
    lane_mask_t m;
    int         v;
    int         occ;
    bit         fire;

    m = row.mask;
    if (row.base == 0) begin
      m = lane_mask_t'($random(seed));
    end
    // upstream holds conflicts back while skip is up
    if (row.respect && skip) begin
      m = '0;
    end
    for (int l = 0; l < LANE_COUNT; l++) begin
      if (row.base == 0) begin
        op.addr   = vaddr_t'({$random(seed), $random(seed)});
        op.rg     = reg_no_t'($random(seed));
        op.size   = size_t'($random(seed));
        op.lsq    = lsq_t'($random(seed));
        op.thread = 1'($random(seed));
      end else begin
        v = row.base + k * 8 + l;
        op.addr   = vaddr_t'({v, ~v});
        op.rg     = reg_no_t'(v * 5);
        op.size   = size_t'(v + 3);
        op.lsq    = lsq_t'(v ^ 32'h155);
        op.thread = v[2];
      end
      in_addr[l]   = op.addr;
      in_reg[l]    = op.rg;
      in_size[l]   = op.size;
      in_lsq[l]    = op.lsq;
      in_thread[l] = op.thread;
      if (m[l] && !row.exc) begin
        sample_q.push_back(op);
      end
    end
    in_conflict = m;
    except      = row.exc;
    out_ready   = row.ready;

    @(negedge clk);
    compare_field("out_valid", 64'(out_valid), 64'(exp_q.size() != 0));
    if (exp_q.size() != 0) begin
      compare_outputs(exp_q[0]);
    end
    // a stalled op must not move
    if (held && !last_exc) begin
      compare_field("out_valid", 64'(out_valid), 64'(1));
      compare_outputs(held_op);
    end
    if (last_exc) begin
      compare_field("out_valid", 64'(out_valid), 64'(0));
    end
    // skip is allowed one cycle to follow the occupancy
    occ = ent_left.size();
    if (occ >= SKIP_LEVEL && last_occ >= SKIP_LEVEL) begin
      compare_field("skip", 64'(skip), 64'(1));
    end else if (occ < SKIP_LEVEL && last_occ < SKIP_LEVEL) begin
      compare_field("skip", 64'(skip), 64'(0));
    end
    last_occ = occ;
    held     = (exp_q.size() != 0) && !row.ready;
    if (held) begin
      held_op = exp_q[0];
    end
    fire     = (exp_q.size() != 0) && row.ready;

    @(posedge clk);
    #1;
    if (fire) begin
      void'(exp_q.pop_front());
      ent_left[0] = ent_left[0] - 1;
      if (ent_left[0] == 0) begin
        void'(ent_left.pop_front());
      end
    end
    if (row.exc) begin
      exp_q.delete();
      ent_left.delete();
      fly_q.delete();
    end else begin
      if (fly_q.size() != 0) begin
        foreach (fly_q[i]) begin
          exp_q.push_back(fly_q[i]);
        end
        ent_left.push_back(fly_q.size());
      end
      fly_q = sample_q;
    end
    last_exc = row.exc;
  endtask

  initial begin
    int   budget;
    int   n;
    row_t idle;

    rst         = 1'b1;
    except      = 1'b0;
    out_ready   = 1'b0;
    in_conflict = '0;
    for (int l = 0; l < LANE_COUNT; l++) begin
      in_addr[l]   = '0;
      in_reg[l]    = '0;
      in_size[l]   = '0;
      in_lsq[l]    = '0;
      in_thread[l] = 1'b0;
    end

    budget = RESET_CYCLES + DRAIN_LIMIT + 32;
    foreach (table_rows[r]) begin
      budget += table_rows[r].reps;
    end
    fork
      begin
        #(budget * CLK_PERIOD);
        $display("watchdog expired after %0d cycles, the run did not finish", budget);
        $display("Test failed");
        $finish;
      end
    join_none

    repeat (RESET_CYCLES) @(posedge clk);
    #1;
    rst = 1'b0;
    @(negedge clk);
    compare_field("out_valid", 64'(out_valid), 64'(0));
    compare_field("skip", 64'(skip), 64'(0));
    @(posedge clk);
    #1;

    foreach (table_rows[r]) begin
      for (int k = 0; k < table_rows[r].reps; k++) begin
        run_cycle(table_rows[r], k);
      end
    end

    idle = '{3'b000, 32'h010, 1'b0, 1'b1, 1'b1, 1};
    n = 0;
    while ((exp_q.size() != 0 || fly_q.size() != 0) && n < DRAIN_LIMIT) begin
      run_cycle(idle, n);
      n++;
    end
    run_cycle(idle, 0);

    $display("checks: %0d  errors: %0d", checks, errors);
    if (errors == 0) begin
      $display("Test passed");
    end else begin
      $display("Test failed");
    end
    $finish;
  end

endmodule

// File: src.f
verilog/replay_pkg.sv
verilog/mop_capture.sv
verilog/replay_queue.sv
verilog/lane_issue.sv
verilog/addr_replay_top.sv
sim/tb_addr_replay.sv

// File: verilog/addr_replay_top.sv
/*
  conflict replay path
  capture stage, entry queue and lane issue in a chain;
  conflicted lane groups come back out one op per transfer
*/

`timescale 1ns/1ps

module addr_replay_top (
  input  logic                   clk,
  input  logic                   rst,
  input  logic                   except,
  input  replay_pkg::lane_mask_t in_conflict,
  input  replay_pkg::vaddr_t     in_addr   [replay_pkg::LANE_COUNT],
  input  replay_pkg::reg_no_t    in_reg    [replay_pkg::LANE_COUNT],
  input  replay_pkg::size_t      in_size   [replay_pkg::LANE_COUNT],
  input  replay_pkg::lsq_t       in_lsq    [replay_pkg::LANE_COUNT],
  input  logic                   in_thread [replay_pkg::LANE_COUNT],
  input  logic                   out_ready,
  output logic                   out_valid,
  output replay_pkg::vaddr_t     out_addr,
  output replay_pkg::reg_no_t    out_reg,
  output replay_pkg::size_t      out_size,
  output replay_pkg::lsq_t       out_lsq,
  output logic                   out_thread,
  output logic                   skip
);

  // capture to queue
  logic                   wr_en;
  replay_pkg::lane_mask_t wr_mask;
  replay_pkg::mop_word_t  wr_words [replay_pkg::LANE_COUNT];

  // queue to issue
  logic                   head_valid;
  replay_pkg::lane_mask_t head_mask;
  replay_pkg::mop_word_t  head_words [replay_pkg::LANE_COUNT];
  logic                   pop;

  mop_capture u_capture (
    .clk, .rst, .except,
    .in_conflict, .in_addr, .in_reg, .in_size, .in_lsq, .in_thread,
    .wr_en, .wr_mask, .wr_words
  );

  replay_queue u_queue (
    .clk, .rst, .except,
    .wr_en, .wr_mask, .wr_words,
    .pop, .head_valid, .head_mask, .head_words, .skip
  );

  lane_issue u_issue (
    .clk, .rst, .except,
    .head_valid, .head_mask, .head_words, .out_ready, .pop,
    .out_valid, .out_addr, .out_reg, .out_size, .out_lsq, .out_thread
  );

endmodule

// File: verilog/lane_issue.sv
/*
  lane issue stage
  walks the flagged lanes of the head entry lowest lane first,
  one per transfer, unpacks the chosen word onto the output
  fields and pops the entry once its last lane has gone
*/

`timescale 1ns/1ps

module lane_issue (
  input  logic                   clk,
  input  logic                   rst,
  input  logic                   except,
  input  logic                   head_valid,
  input  replay_pkg::lane_mask_t head_mask,
  input  replay_pkg::mop_word_t  head_words [replay_pkg::LANE_COUNT],
  input  logic                   out_ready,
  output logic                   pop,
  output logic                   out_valid,
  output replay_pkg::vaddr_t     out_addr,
  output replay_pkg::reg_no_t    out_reg,
  output replay_pkg::size_t      out_size,
  output replay_pkg::lsq_t       out_lsq,
  output logic                   out_thread
);
  import replay_pkg::*;

  typedef logic [$clog2(LANE_COUNT)-1:0] lane_idx_t;

  lane_mask_t issued;
  lane_mask_t remaining;
  lane_mask_t sel_onehot;
  lane_idx_t  sel_idx;
  logic       last_lane;
  logic       fire;

  assign remaining = head_mask & ~issued;

  // lowest remaining lane wins
  always_comb begin
    sel_onehot = '0;
    sel_idx    = '0;
    for (int i = LANE_COUNT - 1; i >= 0; i--) begin
      if (remaining[i]) begin
        sel_onehot = lane_mask_t'(1) << i;
        sel_idx    = lane_idx_t'(i);
      end
    end
  end

  assign last_lane = ((remaining & ~sel_onehot) == '0);
  assign out_valid = head_valid & (|remaining);
  assign fire      = out_valid & out_ready;
  assign pop       = fire & last_lane;

  assign {out_addr, out_reg, out_size, out_lsq, out_thread} = head_words[sel_idx];

  // lanes of the head entry that have already transferred
  always_ff @(posedge clk) begin
    if (rst || except) begin
      issued <= '0;
    end else if (fire) begin
      if (last_lane) begin
        issued <= '0;
      end else begin
        issued <= issued | sel_onehot;
      end
    end
  end

endmodule

// File: verilog/mop_capture.sv
/*
  micro-op capture stage
  samples the three lanes every clock, drops conflict flags
  while an exception is active and packs each lane into one
  queue word; wr_en marks a group that needs replay
*/

`timescale 1ns/1ps

module mop_capture (
  input  logic                   clk,
  input  logic                   rst,
  input  logic                   except,
  input  replay_pkg::lane_mask_t in_conflict,
  input  replay_pkg::vaddr_t     in_addr   [replay_pkg::LANE_COUNT],
  input  replay_pkg::reg_no_t    in_reg    [replay_pkg::LANE_COUNT],
  input  replay_pkg::size_t      in_size   [replay_pkg::LANE_COUNT],
  input  replay_pkg::lsq_t       in_lsq    [replay_pkg::LANE_COUNT],
  input  logic                   in_thread [replay_pkg::LANE_COUNT],
  output logic                   wr_en,
  output replay_pkg::lane_mask_t wr_mask,
  output replay_pkg::mop_word_t  wr_words  [replay_pkg::LANE_COUNT]
);
  import replay_pkg::*;

  lane_mask_t live_mask;

  // an exception discards the whole group
  assign live_mask = in_conflict & {LANE_COUNT{~except}};

  always_ff @(posedge clk) begin
    if (rst) begin
      wr_en   <= 1'b0;
      wr_mask <= '0;
    end else begin
      wr_en   <= |live_mask;
      wr_mask <= live_mask;
    end
  end

  // payload, only meaningful when wr_en is high
  always_ff @(posedge clk) begin
    for (int i = 0; i < LANE_COUNT; i++) begin
      wr_words[i] <= {in_addr[i], in_reg[i], in_size[i], in_lsq[i], in_thread[i]};
    end
  end

endmodule

// File: verilog/replay_pkg.sv
/*
  replay queue package
  queue and lane sizes plus the vector types of one micro-op
  and of the per-lane conflict mask
*/

package replay_pkg;

  // lanes presented by the address stage each cycle
  localparam int LANE_COUNT = 3;

  // queue geometry
  localparam int QUEUE_DEPTH = 8;
  localparam int QPTR_W = $clog2(QUEUE_DEPTH);
  localparam int QCOUNT_W = $clog2(QUEUE_DEPTH + 1);

  // upstream is told to hold off conflicts from this occupancy on
  localparam int SKIP_LEVEL = 4;

  // micro-op field widths
  localparam int VADDR_W = 44;
  localparam int REG_NO_W = 9;
  localparam int SIZE_W = 5;
  localparam int LSQ_W = 9;

  // packed op, address in the top bits and thread at bit 0
  localparam int MOP_W = VADDR_W + REG_NO_W + SIZE_W + LSQ_W + 1;

  // virtual address
  typedef logic [VADDR_W-1:0] vaddr_t;

  // destination register number
  typedef logic [REG_NO_W-1:0] reg_no_t;

  // access size code
  typedef logic [SIZE_W-1:0] size_t;

  // load/store queue tag
  typedef logic [LSQ_W-1:0] lsq_t;

  // {addr, reg, size, lsq, thread}
  typedef logic [MOP_W-1:0] mop_word_t;

  // one conflict bit per lane, bit 0 is lane 0
  typedef logic [LANE_COUNT-1:0] lane_mask_t;

  // queue slot index
  typedef logic [QPTR_W-1:0] qptr_t;

  // occupancy, 0 up to QUEUE_DEPTH
  typedef logic [QCOUNT_W-1:0] qcount_t;

endpackage

// File: verilog/replay_queue.sv
/*
  replay entry store
  eight groups of three micro-ops kept oldest first with head
  and tail pointers; the oldest entry is always presented at
  the head ports, skip flags half occupancy to upstream and an
  exception empties the queue
*/

`timescale 1ns/1ps

module replay_queue (
  input  logic                   clk,
  input  logic                   rst,
  input  logic                   except,
  input  logic                   wr_en,
  input  replay_pkg::lane_mask_t wr_mask,
  input  replay_pkg::mop_word_t  wr_words   [replay_pkg::LANE_COUNT],
  input  logic                   pop,
  output logic                   head_valid,
  output replay_pkg::lane_mask_t head_mask,
  output replay_pkg::mop_word_t  head_words [replay_pkg::LANE_COUNT],
  output logic                   skip
);
  import replay_pkg::*;

  lane_mask_t mask_mem [QUEUE_DEPTH];
  mop_word_t  word_mem [QUEUE_DEPTH][LANE_COUNT];

  qptr_t   head_ptr;
  qptr_t   tail_ptr;
  qcount_t count;
  qcount_t count_next;
  logic    full;
  logic    do_write;
  logic    do_pop;

  assign full       = (count == qcount_t'(QUEUE_DEPTH));
  assign head_valid = (count != '0);

  // a flush also drops the group still in flight from capture
  assign do_pop   = pop & head_valid;
  assign do_write = wr_en & ~except & (~full | do_pop);

  always_comb begin
    count_next = count;
    if (except) begin
      count_next = '0;
    end else if (do_write && !do_pop) begin
      count_next = count + 1'b1;
    end else if (do_pop && !do_write) begin
      count_next = count - 1'b1;
    end
  end

  always_ff @(posedge clk) begin
    if (rst) begin
      head_ptr <= '0;
      tail_ptr <= '0;
      count    <= '0;
      skip     <= 1'b0;
    end else begin
      count <= count_next;
      // registered against the occupancy of the coming cycle
      skip  <= (count_next >= qcount_t'(SKIP_LEVEL));
      if (except) begin
        head_ptr <= '0;
        tail_ptr <= '0;
      end else begin
        if (do_write) begin
          tail_ptr <= qptr_t'(tail_ptr + 1'b1);
        end
        if (do_pop) begin
          head_ptr <= qptr_t'(head_ptr + 1'b1);
        end
      end
    end
  end

  // entry storage
  always_ff @(posedge clk) begin
    if (do_write) begin
      mask_mem[tail_ptr] <= wr_mask;
      for (int i = 0; i < LANE_COUNT; i++) begin
        word_mem[tail_ptr][i] <= wr_words[i];
      end
    end
  end

  // oldest entry
  assign head_mask = mask_mem[head_ptr];

  always_comb begin
    for (int i = 0; i < LANE_COUNT; i++) begin
      head_words[i] = word_mem[head_ptr][i];
    end
  end

endmodule
